//--- hub75.f
rtl/hub75_pkg.sv
rtl/axil_framebuffer_write.sv
rtl/framebuffer_ram.sv
rtl/framebuffer_fetch.sv
rtl/bitplane_encoder.sv
rtl/panel_scan.sv
rtl/hub75_top.sv
bench/hub75_tb.sv

//--- bench/hub75_tb.sv
module hub75_tb;
    import hub75_pkg::*;

    // one frame is 16 row pairs of four planes, each 64 columns of 6 clocks plus latch
    localparam int frame_cycles = 16 * (4 * (64 * 6 + 2) + 8 * (1 + 2 + 4 + 8));
    localparam int extra_writes = 40;
    localparam int write_cycles = (2048 + extra_writes) * 16;
    localparam int cycle_limit  = 2 * 2 * frame_cycles + write_cycles + 100;

    logic        clk_in;
    logic        reset;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    hub75_rgb_t  panel_rgb;
    logic        panel_clk;
    logic        panel_latch;
    logic        panel_blank;
    row_t        panel_row;

    logic [15:0] mirror [2048];
    logic [31:0] rand_state;
    logic [1:0]  expected_resp;
    logic        check_pixels;
    logic        panel_clk_q;
    logic        panel_blank_q;
    int          cycle_count;
    int          clk_pulses;
    int          latch_count;
    int          blank_low;
    int          pixel_checks;
    int          blank_checks;
    int          responses;
    int          writes_issued;
    int          errors [5];
    bit          test_ok [5];

    hub75_top hub75_top_i (.*);

    always #10 clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one plane bit each of red 15:12, green 10:7 and blue 4:1
    function automatic logic [5:0] expected_rgb(input int latches, input int shift);
        logic [3:0]  row;
        logic [1:0]  plane;
        logic [15:0] top;
        logic [15:0] bottom;
        row    = 4'(latches / 4);
        plane  = 2'(latches % 4);
        top    = mirror[{1'b0, row, ~6'(shift)}];
        bottom = mirror[{1'b1, row, ~6'(shift)}];
        return {top[12 + plane], top[7 + plane], top[1 + plane],
                bottom[12 + plane], bottom[7 + plane], bottom[1 + plane]};
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [15:0] data,
                             input logic [3:0] strb, input int stall);
        expected_resp <= (addr < 32'd4096) ? 2'b00 : 2'b10;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= {~data, data};
        wstrb   <= strb;
        wvalid  <= 1'b1;
        do @(posedge clk_in); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        writes_issued++;
        if (addr < 32'd4096) begin
            if (strb[0]) mirror[addr[11:1]][7:0] = data[7:0];
            if (strb[1]) mirror[addr[11:1]][15:8] = data[15:8];
        end
        do @(posedge clk_in); while (!bvalid);
        repeat (stall) @(posedge clk_in);
        bready <= 1'b1;
        @(posedge clk_in);
        bready <= 1'b0;
    endtask

    task automatic report_test(input int idx, input string name, input bit reached);
        test_ok[idx] = reached && (errors[idx] == 0);
        if (!reached) begin
            $display("test %s was never exercised by the stimulus", name);
        end
        $display("test %s: %0d errors, %s", name, errors[idx], test_ok[idx] ? "ok" : "not ok");
    endtask

    // panel monitor counting shifts, latches and dark time
    always @(posedge clk_in) begin
        panel_clk_q   <= panel_clk;
        panel_blank_q <= panel_blank;
        cycle_count   <= cycle_count + 1;
        if (reset) begin
            clk_pulses  <= 0;
            latch_count <= 0;
            blank_low   <= 0;
        end else begin
            if (panel_clk && !panel_clk_q) begin
                clk_pulses <= clk_pulses + 1;
                if (check_pixels) pixel_checks <= pixel_checks + 1;
            end
            if (panel_latch) begin
                clk_pulses  <= 0;
                latch_count <= latch_count + 1;
            end
            if (!panel_blank) begin
                blank_low <= blank_low + 1;
            end else if (!panel_blank_q) begin
                blank_low    <= 0;
                blank_checks <= blank_checks + 1;
            end
            if (bvalid && bready) responses <= responses + 1;
        end
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    reset_state: assert property (@(posedge clk_in)
        (reset && cycle_count > 0) || $fell(reset) |->
            panel_blank && !panel_latch && !panel_clk && !bvalid && awready && wready)
    else begin
        errors[0]++;
        $display("CHECK FAILED at %0t: outputs not in reset state", $time);
    end

    resp_value: assert property (@(posedge clk_in) disable iff (reset)
        bvalid |-> bresp == expected_resp)
    else begin
        errors[1]++;
        $display("CHECK FAILED at %0t: bresp %b, expected %b", $time, $sampled(bresp),
                 $sampled(expected_resp));
    end

    resp_held: assert property (@(posedge clk_in) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp) && !awready && !wready)
    else begin
        errors[1]++;
        $display("CHECK FAILED at %0t: response not held under back-pressure", $time);
    end

    shifted_bits: assert property (@(posedge clk_in) disable iff (reset)
        $rose(panel_clk) && check_pixels |-> panel_rgb == expected_rgb(latch_count, clk_pulses))
    else begin
        errors[2]++;
        $display("CHECK FAILED at %0t: panel_rgb %b, expected %b at latch %0d column %0d",
                 $time, $sampled(panel_rgb),
                 expected_rgb($sampled(latch_count), $sampled(clk_pulses)),
                 $sampled(latch_count), $sampled(clk_pulses));
    end

    clk_bounded: assert property (@(posedge clk_in) disable iff (reset)
        $rose(panel_clk) |-> clk_pulses < 64)
    else begin
        errors[3]++;
        $display("CHECK FAILED at %0t: more than 64 panel clocks before a latch", $time);
    end

    latch_sequence: assert property (@(posedge clk_in) disable iff (reset)
        panel_latch |-> clk_pulses == 64 && panel_blank && panel_row == 4'(latch_count / 4))
    else begin
        errors[3]++;
        $display("CHECK FAILED at %0t: latch after %0d clocks, blank %b, row %0d",
                 $time, $sampled(clk_pulses), $sampled(panel_blank), $sampled(panel_row));
    end

    display_time: assert property (@(posedge clk_in) disable iff (reset)
        $rose(panel_blank) |-> blank_low == (8 << ((latch_count - 1) % 4)))
    else begin
        errors[4]++;
        $display("CHECK FAILED at %0t: blank low for %0d cycles after latch %0d",
                 $time, $sampled(blank_low), $sampled(latch_count));
    end

    initial begin
        int          target;
        int          failed;
        logic [31:0] addr;
        clk_in        = 1'b0;
        reset         = 1'b1;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        expected_resp = 2'b00;
        check_pixels  = 1'b0;
        rand_state    = 32'h858f_e1e9;
        cycle_count   = 0;
        pixel_checks  = 0;
        blank_checks  = 0;
        responses     = 0;
        writes_issued = 0;
        errors        = '{default: 0};
        repeat (16) @(posedge clk_in);
        reset <= 1'b0;
        repeat (2) @(posedge clk_in);
        report_test(0, "reset state", 1'b1);

        // fill the whole framebuffer
        for (int i = 0; i < 2048; i++) begin
            rand_state = xorshift32(rand_state);
            axi_write(32'(i * 2), rand_state[15:0], 4'b0011, int'(rand_state[17:16]));
        end
        // single-lane rewrites with an out-of-range write every eighth time
        for (int i = 0; i < extra_writes; i++) begin
            rand_state = xorshift32(rand_state);
            if (i % 8 == 7) begin
                addr = 32'h1000 | (32'(rand_state[27:20]) << 4);
                axi_write(addr, rand_state[15:0], 4'b0011, int'(rand_state[30:28]));
            end else begin
                addr = {20'h0, rand_state[26:16], 1'b0};
                axi_write(addr, rand_state[15:0], rand_state[31] ? 4'b0010 : 4'b0001,
                          int'(rand_state[30:28]));
            end
        end
        @(posedge clk_in);
        report_test(1, "write responses", responses == writes_issued);

        // start comparing once a plane begins after the last write
        do @(posedge clk_in); while (!panel_latch);
        check_pixels <= 1'b1;
        target = latch_count + 2 * 64;
        do @(posedge clk_in); while (latch_count < target);
        report_test(2, "shifted colour bits", pixel_checks > 0);
        report_test(3, "shift and latch sequence", latch_count > 0);
        report_test(4, "plane display time", blank_checks > 0);

        failed = 0;
        foreach (test_ok[i]) begin
            if (!test_ok[i]) failed++;
        end
        $display("summary: %0d tests, %0d ok, %0d not ok", 5, 5 - failed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- rtl/hub75_top.sv
module hub75_top (
    input  logic                  clk_in,
    input  logic                  reset,

    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,

    output hub75_pkg::hub75_rgb_t panel_rgb,
    output logic                  panel_clk,
    output logic                  panel_latch,
    output logic                  panel_blank,
    output hub75_pkg::row_t       panel_row
);
    import hub75_pkg::*;

    fb_write_t   fb_write;
    logic        fb_write_valid;
    fb_addr_t    ram_address;
    logic        ram_read_enable;
    rgb565_t     ram_data;
    pixel_pair_t pixel_pair;
    logic        fetch_start;
    column_t     column;
    row_t        row;
    plane_t      plane;

    axil_framebuffer_write axil_framebuffer_write_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bresp          (bresp),
        .bready         (bready),
        .fb_write       (fb_write),
        .fb_write_valid (fb_write_valid)
    );

    framebuffer_ram framebuffer_ram_i (
        .clk_in          (clk_in),
        .fb_write        (fb_write),
        .fb_write_valid  (fb_write_valid),
        .ram_read_enable (ram_read_enable),
        .ram_address     (ram_address),
        .ram_data        (ram_data)
    );

    panel_scan panel_scan_i (
        .clk_in      (clk_in),
        .reset       (reset),
        .fetch_start (fetch_start),
        .column      (column),
        .row         (row),
        .plane       (plane),
        .panel_clk   (panel_clk),
        .panel_latch (panel_latch),
        .panel_blank (panel_blank),
        .panel_row   (panel_row)
    );

    framebuffer_fetch framebuffer_fetch_i (
        .clk_in          (clk_in),
        .reset           (reset),
        .fetch_start     (fetch_start),
        .column          (column),
        .row             (row),
        .ram_data        (ram_data),
        .ram_address     (ram_address),
        .ram_read_enable (ram_read_enable),
        .pixel_pair      (pixel_pair)
    );

    bitplane_encoder bitplane_encoder_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .pixel_pair (pixel_pair),
        .plane      (plane),
        .rgb        (panel_rgb)
    );

endmodule

//--- rtl/panel_scan.sv
module panel_scan (
    input  logic               clk_in,
    input  logic               reset,

    output logic               fetch_start,
    output hub75_pkg::column_t column,
    output hub75_pkg::row_t    row,
    output hub75_pkg::plane_t  plane,

    output logic               panel_clk,
    output logic               panel_latch,
    output logic               panel_blank,
    output hub75_pkg::row_t    panel_row
);
    import hub75_pkg::*;

    typedef enum logic [1:0] {
        state_shift,
        state_blank_pre,
        state_latch,
        state_display
    } scan_state_t;

    scan_state_t state;
    logic [2:0]  phase;
    logic [6:0]  delay;
    logic        last_phase;

    assign last_phase  = (phase == 3'(column_cycles - 1));
    assign fetch_start = (state == state_shift) && (phase == 3'd0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= state_shift;
            phase       <= 3'd0;
            delay       <= 7'd0;
            column      <= '0;
            row         <= '0;
            plane       <= '0;
            panel_clk   <= 1'b0;
            panel_latch <= 1'b0;
            panel_blank <= 1'b1;
            panel_row   <= '0;
        end else begin
            // encoded bits settle one clock before this rising edge
            panel_clk   <= (state == state_shift) && last_phase;
            panel_latch <= 1'b0;

            case (state)
                state_shift: begin
                    if (last_phase) begin
                        phase <= 3'd0;
                        if (column == column_t'(panel_columns - 1)) begin
                            column <= '0;
                            state  <= state_blank_pre;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end

                // let the last panel clock finish before the latch
                state_blank_pre: begin
                    panel_latch <= 1'b1;
                    panel_row   <= row;
                    state       <= state_latch;
                end

                state_latch: begin
                    // binary weighted on time
                    delay       <= 7'((plane_base_cycles << plane) - 1);
                    panel_blank <= 1'b0;
                    state       <= state_display;
                end

                state_display: begin
                    if (delay == 7'd0) begin
                        panel_blank <= 1'b1;
                        state       <= state_shift;
                        if (plane == plane_t'(plane_count - 1)) begin
                            plane <= '0;
                            if (row == row_t'(panel_row_pairs - 1)) begin
                                row <= '0;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end

                default: state <= state_shift;
            endcase
        end
    end

    // the panel must be dark and idle while the shift register is latched
    latch_while_blank: assert property (
        @(posedge clk_in) disable iff (reset)
        panel_latch |-> panel_blank && !panel_clk
    );

endmodule

//--- rtl/bitplane_encoder.sv
module bitplane_encoder (
    input  logic                   clk_in,
    input  logic                   reset,

    input  hub75_pkg::pixel_pair_t pixel_pair,
    input  hub75_pkg::plane_t      plane,

    output hub75_pkg::hub75_rgb_t  rgb
);
    import hub75_pkg::*;

    hub75_rgb_t rgb_next;

    // red, green and blue bit of one pixel for the given plane
    function automatic logic [2:0] plane_bits(input rgb565_t pixel, input plane_t p);
        logic red;
        logic green;
        logic blue;
        red   = pixel[red_plane_lsb + p];
        // green keeps only its upper four of six bits
        green = pixel[green_plane_lsb + p];
        blue  = pixel[blue_plane_lsb + p];
        return {red, green, blue};
    endfunction

    always_comb begin
        {rgb_next.r1, rgb_next.g1, rgb_next.b1} = plane_bits(pixel_pair.top, plane);
        {rgb_next.r2, rgb_next.g2, rgb_next.b2} = plane_bits(pixel_pair.bottom, plane);
    end

    // panel data lines start dark
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_next;
        end
    end

endmodule

//--- rtl/framebuffer_fetch.sv
module framebuffer_fetch (
    input  logic                   clk_in,
    input  logic                   reset,

    input  logic                   fetch_start,
    input  hub75_pkg::column_t     column,
    input  hub75_pkg::row_t        row,

    input  hub75_pkg::rgb565_t     ram_data,
    output hub75_pkg::fb_addr_t    ram_address,
    output logic                   ram_read_enable,

    output hub75_pkg::pixel_pair_t pixel_pair
);
    import hub75_pkg::*;

    logic [1:0] count;
    logic       half;
    rgb565_t    top_pixel;

    // count 3 reads the upper half, count 2 the lower half
    assign half            = (count == 2'd2);
    assign ram_read_enable = (count != 2'd0);

    // panel columns are wired right to left
    assign ram_address = {half, row, ~column};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= 2'd0;
        end else if (fetch_start) begin
            count <= 2'(fetch_cycles);
        end else if (count != 2'd0) begin
            count <= count - 1'b1;
        end
    end

    // ram output lags the address by one clock
    always_ff @(posedge clk_in) begin
        if (count == 2'd2) begin
            top_pixel <= ram_data;
        end
        // publish both halves together so the pair never mixes columns
        if (count == 2'd1) begin
            pixel_pair <= '{top: top_pixel, bottom: ram_data};
        end
    end

    // the scan controller has to leave room for the whole read sequence
    no_overlapping_fetch: assert property (
        @(posedge clk_in) disable iff (reset)
        fetch_start |-> count == 2'd0
    );

endmodule

//--- rtl/framebuffer_ram.sv
module framebuffer_ram (
    input  logic                 clk_in,

    input  hub75_pkg::fb_write_t fb_write,
    input  logic                 fb_write_valid,

    input  logic                 ram_read_enable,
    input  hub75_pkg::fb_addr_t  ram_address,
    output hub75_pkg::rgb565_t   ram_data
);
    import hub75_pkg::*;

    rgb565_t mem [framebuffer_words];

    // host port, one byte lane per enable bit
    always_ff @(posedge clk_in) begin
        if (fb_write_valid) begin
            if (fb_write.byte_enable[0]) begin
                mem[fb_write.address][7:0] <= fb_write.data[7:0];
            end
            if (fb_write.byte_enable[1]) begin
                mem[fb_write.address][15:8] <= fb_write.data[15:8];
            end
        end
    end

    // scan port, output register only moves when enabled
    always_ff @(posedge clk_in) begin
        if (ram_read_enable) begin
            ram_data <= mem[ram_address];
        end
    end

endmodule

//--- rtl/axil_framebuffer_write.sv
module axil_framebuffer_write (
    input  logic                 clk_in,
    input  logic                 reset,

    input  logic [31:0]          awaddr,
    input  logic                 awvalid,
    output logic                 awready,

    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,

    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  logic                 bready,

    output hub75_pkg::fb_write_t fb_write,
    output logic                 fb_write_valid
);
    import hub75_pkg::*;

    logic       aw_full;
    logic       w_full;
    fb_addr_t   aw_word;
    logic       aw_in_range;
    rgb565_t    w_data;
    logic [1:0] w_strb;

    logic aw_take;
    logic w_take;
    logic issue;

    // a channel is open while its holding slot is free and no response waits
    assign awready = !aw_full && !bvalid;
    assign wready  = !w_full && !bvalid;
    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;

    // both beats held, so the write goes out this cycle
    assign issue = aw_full && w_full;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            aw_full        <= 1'b0;
            w_full         <= 1'b0;
            bvalid         <= 1'b0;
            bresp          <= axi_resp_okay;
            fb_write_valid <= 1'b0;
        end else begin
            fb_write_valid <= issue && aw_in_range;

            if (aw_take) begin
                aw_full <= 1'b1;
            end else if (issue) begin
                aw_full <= 1'b0;
            end

            if (w_take) begin
                w_full <= 1'b1;
            end else if (issue) begin
                w_full <= 1'b0;
            end

            if (issue) begin
                bvalid <= 1'b1;
                bresp  <= aw_in_range ? axi_resp_okay : axi_resp_slverr;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // beat contents, qualified by the full flags
    always_ff @(posedge clk_in) begin
        if (aw_take) begin
            aw_word     <= awaddr[11:1];
            aw_in_range <= (awaddr < framebuffer_bytes);
        end
        if (w_take) begin
            w_data <= wdata[15:0];
            w_strb <= wstrb[1:0];
        end
        if (issue) begin
            fb_write <= '{address: aw_word, data: w_data, byte_enable: w_strb};
        end
    end

    // response must wait for the master, unchanged
    bresp_held: assert property (
        @(posedge clk_in) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

//--- rtl/hub75_pkg.sv
package hub75_pkg;

    // panel geometry, one scan line drives an upper and a lower row
    localparam int panel_columns     = 64;
    localparam int panel_row_pairs   = 16;
    localparam int plane_count       = 4;
    localparam int plane_base_cycles = 8;

    // scan pipeline timing
    localparam int column_cycles = 6;
    localparam int fetch_cycles  = 3;

    // framebuffer size
    localparam int framebuffer_words = 2048;
    localparam int framebuffer_bytes = 4096;

    // lowest displayed bit of each RGB565 channel
    localparam int red_plane_lsb   = 12;
    localparam int green_plane_lsb = 7;
    localparam int blue_plane_lsb  = 1;

    localparam logic [1:0] axi_resp_okay  = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    typedef logic [15:0] rgb565_t;
    typedef logic [10:0] fb_addr_t;
    typedef logic [5:0]  column_t;
    typedef logic [3:0]  row_t;
    typedef logic [1:0]  plane_t;

    typedef struct packed {
        fb_addr_t   address;
        rgb565_t    data;
        logic [1:0] byte_enable;
    } fb_write_t;

    typedef struct packed {
        rgb565_t top;
        rgb565_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic r1;
        logic g1;
        logic b1;
        logic r2;
        logic g2;
        logic b2;
    } hub75_rgb_t;

endpackage
